// ==== if_else_eval.f ====
src/if_else_pkg.sv
src/tok_if.sv
src/cond_if.sv
src/char_lexer.sv
src/stmt_parser.sv
src/cond_evaluator.sv
src/if_else_eval_top.sv
sim/tb_if_else_eval.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f if_else_eval.f \
    --top-module tb_if_else_eval -o tb_if_else_eval
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_if_else_eval > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
exit 1

// ==== sim/tb_if_else_eval.sv ====
`timescale 1ns/1ps

module tb_if_else_eval import if_else_pkg::*; ();

    localparam int num_stmts = 40;
    localparam int wd_ns     = num_stmts * 60 * 20 * 2;

    logic  clk;
    logic  rst;
    data_t x;
    char_t ascii_char;
    logic  char_valid;
    data_t p;
    char_t name_p;
    logic  parsing_done;
    logic  error_flag;
    err_t  error_code;

    // Model side
    logic        mark;          // High with the final 'd' of a statement that must finish
    logic [2:0]  mark_pipe;
    data_t       exp_p;
    char_t       exp_name;
    logic        err_expected;
    err_t        exp_code;
    logic [31:0] rng;
    int          sent_count;
    int          done_seen;
    int          val_errs;
    int          other_errs;

    if_else_eval_top i_if_else_eval_top (
        .clk          (clk),
        .rst          (rst),
        .x            (x),
        .ascii_char   (ascii_char),
        .char_valid   (char_valid),
        .p            (p),
        .name_p       (name_p),
        .parsing_done (parsing_done),
        .error_flag   (error_flag),
        .error_code   (error_code)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk or posedge rst) begin
        if (rst)
            mark_pipe <= '0;
        else
            mark_pipe <= {mark_pipe[1:0], mark};
    end

    always @(posedge clk) begin
        if (parsing_done)
            done_seen <= done_seen + 1;
    end

    a_done_on_time: assert property (
        @(posedge clk) disable iff (rst) mark_pipe[2] |-> parsing_done
    ) else begin
        other_errs++;
        $display("parsing_done did not pulse 3 cycles after the final character");
    end

    a_no_stray_done: assert property (
        @(posedge clk) disable iff (rst) parsing_done |-> mark_pipe[2]
    ) else begin
        other_errs++;
        $display("parsing_done pulsed without a completed valid statement");
    end

    a_p_value: assert property (
        @(posedge clk) disable iff (rst) parsing_done |-> p == exp_p
    ) else begin
        val_errs++;
        $display("[FAIL] p expected %h got %h", $sampled(exp_p), $sampled(p));
    end

    a_name_value: assert property (
        @(posedge clk) disable iff (rst) parsing_done |-> name_p == exp_name
    ) else begin
        val_errs++;
        $display("[FAIL] name_p expected %h got %h", $sampled(exp_name), $sampled(name_p));
    end

    a_no_false_error: assert property (
        @(posedge clk) disable iff (rst) error_flag |-> err_expected
    ) else begin
        other_errs++;
        $display("error_flag rose on a statement that should be accepted");
    end

    a_error_code: assert property (
        @(posedge clk) disable iff (rst) error_flag |-> error_code == exp_code
    ) else begin
        val_errs++;
        $display("[FAIL] error_code expected %h got %h", $sampled(exp_code),
                 $sampled(error_code));
    end

    a_error_sticky: assert property (
        @(posedge clk) disable iff (rst) error_flag |=> error_flag
    ) else begin
        other_errs++;
        $display("error_flag dropped before reset");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic int rand_upto(input int n);
        rng = xorshift32(rng);
        return int'(rng % 32'(n));
    endfunction

    function automatic char_t rand_letter();
        return char_t'(97 + rand_upto(26));
    endfunction

    function automatic string cmp_text(input cmp_t c);
        case (c)
            cmp_eq:  return "==";
            cmp_ne:  return "!=";
            cmp_lt:  return "<";
            cmp_gt:  return ">";
            cmp_le:  return "<=";
            default: return ">=";
        endcase
    endfunction

    function automatic logic cond_holds(input cmp_t c, input int xv, input int v);
        case (c)
            cmp_eq:  return xv == v;
            cmp_ne:  return xv != v;
            cmp_lt:  return xv < v;
            cmp_gt:  return xv > v;
            cmp_le:  return xv <= v;
            default: return xv >= v;
        endcase
    endfunction

    function automatic string aop_text(input int sel);
        if (sel == 0)
            return "<=";
        else
            return "=";
    endfunction

    function automatic string build_stmt(input char_t cv, input cmp_t c, input int vc,
                                         input char_t av, input string aop, input int kt,
                                         input char_t bv, input int ke);
        return $sformatf("if(%c%s%0d)begin%c%s%0d;endelsebegin%c%s%0d;end",
                         cv, cmp_text(c), vc, av, aop, kt, bv, aop, ke);
    endfunction

    // Drives one character per falling edge and leaves char_valid high
    task automatic send_stmt(input string s, input logic expect_done, input data_t xv,
                             input data_t pv, input char_t nv);
        for (int i = 0; i < s.len(); i++) begin
            @(negedge clk);
            ascii_char = char_t'(s[i]);
            char_valid = 1'b1;
            mark       = 1'b0;
            if (i == s.len() - 1 && expect_done) begin
                x        = xv;  // Held until the next statement ends
                exp_p    = pv;
                exp_name = nv;
                mark     = 1'b1;
            end
        end
        if (expect_done)
            sent_count++;
    endtask

    task automatic eval_random(input cmp_t c, input logic neg_only, input string aop);
        int    vc;
        int    kt;
        int    ke;
        int    xv;
        char_t cv;
        char_t av;
        if (neg_only) begin
            vc = -rand_upto(1000) - 1;
            kt = -rand_upto(1000) - 1;
            ke = -rand_upto(1000) - 1;
        end else begin
            vc = rand_upto(2001) - 1000;
            kt = rand_upto(2001) - 1000;
            ke = rand_upto(2001) - 1000;
        end
        xv = vc + rand_upto(7) - 3;     // Close to vc so every outcome shows up
        cv = rand_letter();
        av = rand_letter();
        send_stmt(build_stmt(cv, c, vc, av, aop, kt, av, ke), 1'b1, data_t'(xv),
                  data_t'(cond_holds(c, xv, vc) ? kt : ke), av);
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        @(negedge clk);
        char_valid = 1'b0;
        mark       = 1'b0;
        while (done_seen != sent_count && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (done_seen != sent_count) begin
            other_errs++;
            $display("Timed out waiting for parsing_done");
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst        = 1'b1;
        char_valid = 1'b0;
        mark       = 1'b0;
        repeat (5) @(negedge clk);
        rst          = 1'b0;
        err_expected = 1'b0;
        exp_code     = err_none;
    endtask

    // Sends a bad statement and an optional valid one before the reset
    task automatic check_error(input string s, input err_t code, input logic send_valid);
        int n;
        n            = 0;
        err_expected = 1'b1;
        exp_code     = code;
        send_stmt(s, 1'b0, x, exp_p, exp_name);
        if (send_valid)
            send_stmt("if(a>0)beginc=1;endelsebeginc=2;end", 1'b0, x, exp_p, exp_name);
        @(negedge clk);
        char_valid = 1'b0;
        while (!error_flag && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (!error_flag) begin
            other_errs++;
            $display("error_flag never rose for a bad statement");
        end
        repeat (5) @(negedge clk);
        apply_reset();
    endtask

    initial begin
        rst          = 1'b1;
        x            = '0;
        ascii_char   = '0;
        char_valid   = 1'b0;
        mark         = 1'b0;
        exp_p        = '0;
        exp_name     = '0;
        err_expected = 1'b0;
        exp_code     = err_none;
        rng          = 32'h2a48;
        sent_count   = 0;
        done_seen    = 0;
        val_errs     = 0;
        other_errs   = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        for (int k = 0; k < 6; k++) begin
            repeat (4) begin
                eval_random(cmp_t'(k), 1'b0, aop_text(rand_upto(2)));
                wait_done();
            end
        end

        // Negative values including "<-" and ">-"
        for (int k = 0; k < 6; k++) begin
            eval_random(cmp_t'(k), 1'b1, aop_text(k % 2));
            wait_done();
        end

        repeat (3)
            eval_random(cmp_t'(rand_upto(6)), 1'b0, aop_text(rand_upto(2)));
        wait_done();

        check_error(build_stmt(char_t'("a"), cmp_lt, 5, char_t'("a"), "=", 1,
                               char_t'("b"), 2),
                    err_var_mismatch, 1'b0);
        check_error("if(a==5)begina=3endelsebegina=4;end", err_missing_semicolon, 1'b0);
        check_error("if(a=5)begina=3;endelsebegina=4;end", err_missing_operator, 1'b0);
        check_error("iff(a==1)beginb=2;endelsebeginb=3;end", err_keyword, 1'b1);
        check_error("if(#==1)beginb=2;endelsebeginb=3;end", err_invalid_char, 1'b1);

        $display("Errors: %0d value, %0d other", val_errs, other_errs);
        if (val_errs + other_errs == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial begin
        #(wd_ns);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== src/if_else_eval_top.sv ====
`timescale 1ns/1ps

module if_else_eval_top import if_else_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  data_t x,
    input  char_t ascii_char,
    input  logic  char_valid,
    output data_t p,
    output char_t name_p,
    output logic  parsing_done,
    output logic  error_flag,
    output err_t  error_code
);

    tok_if  tok ();
    cond_if res ();

    char_lexer i_char_lexer (
        .clk        (clk),
        .rst        (rst),
        .ascii_char (ascii_char),
        .char_valid (char_valid),
        .tok        (tok.lexer)
    );

    stmt_parser i_stmt_parser (
        .clk        (clk),
        .rst        (rst),
        .tok        (tok.parser),
        .res        (res.parser),
        .error_flag (error_flag),
        .error_code (error_code)
    );

    cond_evaluator i_cond_evaluator (
        .clk          (clk),
        .rst          (rst),
        .x            (x),
        .res          (res.evaluator),
        .p            (p),
        .name_p       (name_p),
        .parsing_done (parsing_done)
    );

endmodule

// ==== src/cond_evaluator.sv ====
`timescale 1ns/1ps

module cond_evaluator import if_else_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  data_t      x,
    cond_if.evaluator  res,
    output data_t      p,
    output char_t      name_p,
    output logic       parsing_done
);

    logic hit;

    always_comb begin
        case (res.cmp)
            cmp_eq:  hit = x == res.val_c;
            cmp_ne:  hit = x != res.val_c;
            cmp_lt:  hit = x < res.val_c;
            cmp_gt:  hit = x > res.val_c;
            cmp_le:  hit = x <= res.val_c;
            cmp_ge:  hit = x >= res.val_c;
            default: hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            p            <= '0;
            name_p       <= '0;
            parsing_done <= 1'b0;
        end else begin
            parsing_done <= res.valid;
            if (res.valid) begin
                p      <= hit ? res.const_then : res.const_else;
                name_p <= res.var_name;
            end
        end
    end

    a_cmp_is_comparator: assert property (
        @(posedge clk) disable iff (rst)
        res.valid |-> (res.cmp != cmp_assign && res.cmp != cmp_bang)
    );

endmodule

// ==== src/stmt_parser.sv ====
`timescale 1ns/1ps

module stmt_parser import if_else_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    tok_if.parser  tok,
    cond_if.parser res,
    output logic   error_flag,
    output err_t   error_code
);

    typedef enum logic [3:0] {
        s_if,       // Idle at index 0
        s_lpar,
        s_cvar,
        s_cop,
        s_cnum,
        s_begin,
        s_avar,
        s_aop,
        s_anum,
        s_end,
        s_else
    } state_t;

    state_t     state, nxt_state;
    logic [2:0] idx, nxt_idx;      // Letter position inside a keyword
    logic       in_else, nxt_else;
    err_t       err;
    logic       done;
    logic       take;
    logic       num_follows;

    // Keyword letters are left aligned, one byte each
    function automatic char_t kw_char(state_t s, logic [2:0] i);
        logic [39:0] word;
        case (s)
            s_if:    word = {"if", 24'd0};
            s_begin: word = "begin";
            s_end:   word = {"end", 16'd0};
            default: word = {"else", 8'd0};
        endcase
        return word[32 - 8 * i +: 7];
    endfunction

    function automatic logic [2:0] kw_last(state_t s);
        case (s)
            s_if:    return 3'd1;
            s_begin: return 3'd4;
            s_end:   return 3'd2;
            default: return 3'd3;
        endcase
    endfunction

    // Operator must be followed by a number
    assign num_follows = tok.ch == ch_eq || is_digit(tok.ch) || tok.ch == ch_minus;
    assign take        = tok.valid && !error_flag && err == err_none;

    always_comb begin
        nxt_state = state;
        nxt_idx   = idx;
        nxt_else  = in_else;
        err       = err_none;
        done      = 1'b0;
        if (tok.valid && !error_flag) begin
            if (tok.kind == tk_bad) begin
                err = err_syntax;
            end else if (!is_legal(tok.ch)) begin
                err = err_invalid_char;
            end else begin
                case (state)
                    s_if, s_begin, s_end, s_else: begin
                        if (tok.kind != tk_char) begin
                            err = err_syntax;
                        end else if (tok.ch != kw_char(state, idx)) begin
                            err = err_keyword;
                        end else if (idx != kw_last(state)) begin
                            nxt_idx = idx + 3'd1;
                        end else begin
                            nxt_idx = '0;
                            case (state)
                                s_if:    nxt_state = s_lpar;
                                s_begin: nxt_state = s_avar;
                                s_else: begin
                                    nxt_state = s_begin;
                                    nxt_else  = 1'b1;
                                end
                                default: begin
                                    if (in_else) begin
                                        done      = 1'b1;   // Final 'd'
                                        nxt_state = s_if;
                                        nxt_else  = 1'b0;
                                    end else begin
                                        nxt_state = s_else;
                                    end
                                end
                            endcase
                        end
                    end
                    s_lpar: begin
                        if (tok.kind == tk_char && tok.ch == ch_lpar)
                            nxt_state = s_cvar;
                        else if (tok.kind == tk_char && is_letter(tok.ch))
                            err = err_keyword;  // Keyword runs on, as in "iff"
                        else
                            err = err_syntax;
                    end
                    s_cvar: begin
                        if (tok.kind == tk_char && is_letter(tok.ch))
                            nxt_state = s_cop;
                        else
                            err = err_syntax;
                    end
                    s_cop: begin
                        if (tok.kind != tk_op)
                            err = err_syntax;
                        else if (tok.op == cmp_assign || tok.op == cmp_bang)
                            err = err_missing_operator;
                        else if (!num_follows)
                            err = err_syntax;
                        else
                            nxt_state = s_cnum;
                    end
                    s_cnum: begin
                        if (tok.kind == tk_num && tok.ch == ch_rpar)
                            nxt_state = s_begin;
                        else
                            err = err_syntax;
                    end
                    s_avar: begin
                        if (tok.kind != tk_char || !is_letter(tok.ch))
                            err = err_syntax;
                        else if (in_else && tok.ch != res.var_name)
                            err = err_var_mismatch;
                        else
                            nxt_state = s_aop;
                    end
                    s_aop: begin
                        if (tok.kind == tk_op && num_follows &&
                            (tok.op == cmp_le || tok.op == cmp_assign))
                            nxt_state = s_anum;
                        else
                            err = err_syntax;
                    end
                    s_anum: begin
                        if (tok.kind != tk_num)
                            err = err_syntax;
                        else if (tok.ch != ch_semi)
                            err = err_missing_semicolon;
                        else
                            nxt_state = s_end;
                    end
                    default: nxt_state = s_if;
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= s_if;
            idx        <= '0;
            in_else    <= 1'b0;
            error_flag <= 1'b0;
            error_code <= err_none;
            res.valid  <= 1'b0;
        end else begin
            res.valid <= done;
            if (err != err_none) begin
                error_flag <= 1'b1;     // Frozen from here on
                error_code <= err;
            end else begin
                state   <= nxt_state;
                idx     <= nxt_idx;
                in_else <= nxt_else;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            case (state)
                s_cop:   res.cmp <= tok.op;
                s_cnum:  res.val_c <= tok.value;
                s_avar: begin
                    if (!in_else)
                        res.var_name <= tok.ch;
                end
                s_anum: begin
                    if (in_else)
                        res.const_else <= tok.value;
                    else
                        res.const_then <= tok.value;
                end
                default: ;
            endcase
        end
    end

    a_no_result_on_error: assert property (
        @(posedge clk) disable iff (rst) !(res.valid && error_flag)
    );

endmodule

// ==== src/char_lexer.sv ====
`timescale 1ns/1ps

module char_lexer import if_else_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  char_t ascii_char,
    input  logic  char_valid,
    tok_if.lexer  tok
);

    logic  pend_valid;  // Operator char waiting to see if '=' follows
    char_t pend_ch;
    data_t acc;
    logic  neg;
    logic  in_num;      // At least one digit seen

    logic      emit;
    tok_kind_t emit_kind;
    cmp_t      emit_op;

    function automatic cmp_t op_code(char_t c, logic eq);
        case (c)
            ch_lt:   return eq ? cmp_le : cmp_lt;
            ch_gt:   return eq ? cmp_ge : cmp_gt;
            ch_eq:   return eq ? cmp_eq : cmp_assign;
            default: return eq ? cmp_ne : cmp_bang;
        endcase
    endfunction

    always_comb begin
        emit      = 1'b0;
        emit_kind = tk_char;
        emit_op   = op_code(pend_ch, ascii_char == ch_eq);
        if (char_valid) begin
            if (pend_valid) begin
                emit      = 1'b1;
                emit_kind = tk_op;
            end else if (in_num) begin
                emit      = !is_digit(ascii_char);
                emit_kind = tk_num;
            end else if (neg) begin
                emit      = !is_digit(ascii_char);   // Lone minus
                emit_kind = tk_bad;
            end else begin
                emit = !is_digit(ascii_char) && ascii_char != ch_minus &&
                       !is_op_char(ascii_char);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tok.valid  <= 1'b0;
            pend_valid <= 1'b0;
            neg        <= 1'b0;
            in_num     <= 1'b0;
        end else begin
            tok.valid <= emit;
            if (char_valid) begin
                if (in_num || neg) begin
                    in_num <= is_digit(ascii_char);
                    if (!is_digit(ascii_char))
                        neg <= 1'b0;
                end else begin
                    // Idle or holding an operator, the char may start a new lexeme
                    pend_valid <= is_op_char(ascii_char) &&
                                  !(pend_valid && ascii_char == ch_eq);
                    in_num     <= is_digit(ascii_char);
                    neg        <= ascii_char == ch_minus;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (char_valid) begin
            if (is_op_char(ascii_char))
                pend_ch <= ascii_char;
            if (is_digit(ascii_char))
                acc <= (in_num ? acc * data_t'(10) : '0) + digit_val(ascii_char);
            tok.kind  <= emit_kind;
            tok.ch    <= ascii_char;
            tok.op    <= emit_op;
            tok.value <= neg ? -acc : acc;
        end
    end

    a_tok_after_char: assert property (
        @(posedge clk) disable iff (rst) tok.valid |-> $past(char_valid)
    );

endmodule

// ==== src/cond_if.sv ====
`timescale 1ns/1ps

interface cond_if import if_else_pkg::*; ();

    logic  valid;       // One strobe per completed statement
    cmp_t  cmp;
    data_t val_c;
    data_t const_then;
    data_t const_else;
    char_t var_name;

    modport parser (
        output valid, cmp, val_c, const_then, const_else, var_name
    );

    modport evaluator (
        input valid, cmp, val_c, const_then, const_else, var_name
    );

endinterface

// ==== src/tok_if.sv ====
`timescale 1ns/1ps

interface tok_if import if_else_pkg::*; ();

    logic      valid;   // One-cycle strobe
    tok_kind_t kind;
    data_t     value;
    char_t     ch;      // Terminator for numbers, follower for operators
    cmp_t      op;

    modport lexer (
        output valid, kind, value, ch, op
    );

    modport parser (
        input valid, kind, value, ch, op
    );

endinterface

// ==== src/if_else_pkg.sv ====
package if_else_pkg;

    localparam int data_w = 32;
    localparam int char_w = 7;

    typedef logic signed [data_w-1:0] data_t;
    typedef logic [char_w-1:0]        char_t;

    typedef enum logic [1:0] {
        tk_char,    // Letter or punctuation
        tk_num,     // Number, ch holds its terminator
        tk_op,      // Comparator or assignment operator
        tk_bad      // Minus sign without digits
    } tok_kind_t;

    typedef enum logic [2:0] {
        cmp_eq, cmp_ne, cmp_lt, cmp_gt, cmp_le, cmp_ge, cmp_assign, cmp_bang
    } cmp_t;

    typedef enum logic [3:0] {
        err_none              = 4'd0,
        err_keyword           = 4'd1,
        err_var_mismatch      = 4'd2,
        err_invalid_char      = 4'd3,
        err_missing_semicolon = 4'd4,
        err_missing_operator  = 4'd5,
        err_syntax            = 4'd6
    } err_t;

    localparam char_t ch_zero  = char_t'("0");
    localparam char_t ch_nine  = char_t'("9");
    localparam char_t ch_lo_a  = char_t'("a");
    localparam char_t ch_lo_z  = char_t'("z");
    localparam char_t ch_up_a  = char_t'("A");
    localparam char_t ch_up_z  = char_t'("Z");
    localparam char_t ch_lt    = char_t'("<");
    localparam char_t ch_gt    = char_t'(">");
    localparam char_t ch_eq    = char_t'("=");
    localparam char_t ch_bang  = char_t'("!");
    localparam char_t ch_minus = char_t'("-");
    localparam char_t ch_lpar  = char_t'("(");
    localparam char_t ch_rpar  = char_t'(")");
    localparam char_t ch_semi  = char_t'(";");

    function automatic logic is_digit(char_t c);
        return c >= ch_zero && c <= ch_nine;
    endfunction

    function automatic logic is_letter(char_t c);
        return (c >= ch_lo_a && c <= ch_lo_z) || (c >= ch_up_a && c <= ch_up_z);
    endfunction

    function automatic logic is_op_char(char_t c);
        return c == ch_lt || c == ch_gt || c == ch_eq || c == ch_bang;
    endfunction

    // Characters the statement grammar can contain at all
    function automatic logic is_legal(char_t c);
        return is_letter(c) || is_digit(c) || is_op_char(c) || c == ch_minus ||
               c == ch_lpar || c == ch_rpar || c == ch_semi;
    endfunction

    function automatic data_t digit_val(char_t c);
        return data_t'(c - ch_zero);
    endfunction

endpackage
